// File: common/dataeng_consts.svh
// ----------------------------------------------------------------------
// data engine constants
// word and memory sizes, data bus slots, host address layout and
// the bit layout of the configuration word
// ----------------------------------------------------------------------
`ifndef DATAENG_CONSTS_SVH
`define DATAENG_CONSTS_SVH

// word and memory geometry
`define DATA_W         32
`define MEM_ADDR_W     4
`define MEM_DEPTH      (1 << `MEM_ADDR_W)
`define N_MEM          2
`define N_MEM_W        1

// control bit, memory index, word address
`define HOST_ADDR_W    6

// data bus slots, slot k sits at bits k*DATA_W upward
`define N_SRC          6
`define DATABUS_W      (`N_SRC * `DATA_W)
`define BUS_SEL_W      3
`define SRC_MEM0A      0
`define SRC_MEM0B      1
`define SRC_MEM1A      2
`define SRC_MEM1B      3
`define SRC_ALU0       4
`define SRC_MUL0       5

// one memory port: mode, in_sel, start, incr, iter, delay
`define MEMP_CONF_BITS 20
`define MEMP_MODE_B    0
`define MEMP_MODE_W    2
`define MEMP_IN_SEL_B  2
`define MEMP_START_B   5
`define MEMP_INCR_B    9
`define MEMP_ITER_B    13
`define MEMP_ITER_W    5
`define MEMP_DELAY_B   18
`define MEMP_DELAY_W   2
`define MEM_CONF_BITS  (2 * `MEMP_CONF_BITS)

// alu: op, sel_a, sel_b
`define ALU_CONF_BITS  9
`define ALU_OP_B       0
`define ALU_OP_W       3
`define ALU_SEL_A_B    3
`define ALU_SEL_B_B    6

// multiplier: sel_a, sel_b
`define MUL_CONF_BITS  6
`define MUL_SEL_A_B    0
`define MUL_SEL_B_B    3

// unit fields in the full word, 0 / 80 / 89, 95 bits in all
`define CONF_MEM0_B    0
`define CONF_ALU0_B    (`CONF_MEM0_B + `N_MEM * `MEM_CONF_BITS)
`define CONF_MUL0_B    (`CONF_ALU0_B + `ALU_CONF_BITS)
`define CONF_BITS      (`CONF_MUL0_B + `MUL_CONF_BITS)

`endif

// File: common/dataeng_pkg.sv
// ----------------------------------------------------------------------
// data engine package
// unit opcodes, memory port modes, data bus select type and the
// bus word picker shared by every functional unit
// ----------------------------------------------------------------------
`include "dataeng_consts.svh"

package dataeng_pkg;

   // alu operations
   typedef enum logic [2:0] {
      alu_add    = 3'd0,
      alu_sub    = 3'd1,
      alu_and    = 3'd2,
      alu_or     = 3'd3,
      alu_xor    = 3'd4,
      alu_pass_a = 3'd5
   } alu_op_t;

   // memory port modes
   typedef enum logic [1:0] {
      mem_off   = 2'd0,
      mem_read  = 2'd1,
      mem_write = 2'd2
   } mem_mode_t;

   // index of a data bus slot, codes past the last source read zero
   typedef logic [`BUS_SEL_W-1:0] bus_sel_t;

   // one word off the wide data bus
   function automatic logic [`DATA_W-1:0] bus_pick(
      input logic [`DATABUS_W-1:0] bus,
      input bus_sel_t              sel
   );
      if (sel < bus_sel_t'(`N_SRC)) begin
         return bus[sel*`DATA_W +: `DATA_W];
      end
      return '0;
   endfunction

endpackage

// File: mem_unit/addr_gen.sv
// ----------------------------------------------------------------------
// addr_gen
// address generator for one memory port, waits a start delay and
// then steps from start by incr for iter cycles, flags done
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_consts.svh"

module addr_gen (
   input  logic                      rst,
   input  logic                      clk,
   input  logic                      start_run,
   input  logic                      en,
   input  logic [`MEMP_DELAY_W-1:0]  delay,
   input  logic [`MEM_ADDR_W-1:0]    start,
   input  logic [`MEM_ADDR_W-1:0]    incr,
   input  logic [`MEMP_ITER_W-1:0]   iter,
   output logic [`MEM_ADDR_W-1:0]    addr,
   output logic                      active,
   output logic                      done
);

   typedef enum logic [1:0] {st_idle, st_wait, st_step} ag_state_t;

   ag_state_t                 state;
   logic [`MEMP_DELAY_W-1:0]  delay_cnt;
   logic [`MEMP_ITER_W-1:0]   iter_cnt;

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         state     <= st_idle;
         delay_cnt <= '0;
         iter_cnt  <= '0;
         addr      <= '0;
         done      <= 1'b1;
      end else if (start_run) begin
         addr      <= start;
         delay_cnt <= delay;
         iter_cnt  <= iter;
         // disabled port or empty sequence is done at once
         if (!en || iter == '0) begin
            state <= st_idle;
            done  <= 1'b1;
         end else begin
            state <= (delay == '0) ? st_step : st_wait;
            done  <= 1'b0;
         end
      end else begin
         case (state)
            st_wait: begin
               delay_cnt <= delay_cnt - 1'b1;
               if (delay_cnt == `MEMP_DELAY_W'(1))
                  state <= st_step;
            end
            st_step: begin
               // address wraps modulo the memory depth
               addr     <= addr + incr;
               iter_cnt <= iter_cnt - 1'b1;
               if (iter_cnt == `MEMP_ITER_W'(1)) begin
                  state <= st_idle;
                  done  <= 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

   assign active = (state == st_step);

endmodule

// File: mem_unit/mem_unit.sv
// ----------------------------------------------------------------------
// mem_unit
// dual-port data memory, host access through port A when idle and
// per-port read or write streaming against the data bus in a run
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_consts.svh"

module mem_unit import dataeng_pkg::*; (
   input  logic                        rst,
   input  logic                        clk,
   input  logic                        run,
   // host access
   input  logic                        valid,
   input  logic                        we,
   input  logic [`MEM_ADDR_W-1:0]      addr,
   input  logic [`DATA_W-1:0]          wr_data,
   // data bus and configuration
   input  logic [`DATABUS_W-1:0]       data_bus,
   input  logic [`MEM_CONF_BITS-1:0]   config_bits,
   output logic [`DATA_W-1:0]          out_a,
   output logic [`DATA_W-1:0]          out_b,
   output logic                        done_a,
   output logic                        done_b
);

   logic [`DATA_W-1:0]       mem [`MEM_DEPTH];

   wire  [`MEM_ADDR_W-1:0]   gen_addr [2];
   wire  [1:0]               gen_active;
   wire  [1:0]               gen_done;
   mem_mode_t                port_mode [2];
   logic [`DATA_W-1:0]       port_in [2];

   logic [`MEM_ADDR_W-1:0]   addr_a;
   logic [`DATA_W-1:0]       wdata_a;
   logic                     wr_a;
   logic                     wr_b;

   // port A config in the low field, port B above it
   for (genvar p = 0; p < 2; p++) begin : g_port
      logic [`MEMP_CONF_BITS-1:0] conf;

      assign conf         = config_bits[p*`MEMP_CONF_BITS +: `MEMP_CONF_BITS];
      assign port_mode[p] = mem_mode_t'(conf[`MEMP_MODE_B +: `MEMP_MODE_W]);
      assign port_in[p]   = bus_pick(data_bus, bus_sel_t'(conf[`MEMP_IN_SEL_B +: `BUS_SEL_W]));

      addr_gen i_addr_gen (
         .rst       (rst),
         .clk       (clk),
         .start_run (run),
         // unused mode code counts as off
         .en        (port_mode[p] == mem_read || port_mode[p] == mem_write),
         .delay     (conf[`MEMP_DELAY_B +: `MEMP_DELAY_W]),
         .start     (conf[`MEMP_START_B +: `MEM_ADDR_W]),
         .incr      (conf[`MEMP_INCR_B +: `MEM_ADDR_W]),
         .iter      (conf[`MEMP_ITER_B +: `MEMP_ITER_W]),
         .addr      (gen_addr[p]),
         .active    (gen_active[p]),
         .done      (gen_done[p])
      );
   end

   // port A is shared with the host outside a run
   assign addr_a  = gen_active[0] ? gen_addr[0] : addr;
   assign wdata_a = gen_active[0] ? port_in[0] : wr_data;
   assign wr_a    = gen_active[0] ? (port_mode[0] == mem_write) : (valid && we);
   assign wr_b    = gen_active[1] && (port_mode[1] == mem_write);

   // port B write lands last on a clash
   always_ff @(posedge rst) begin
      if (wr_a)
         mem[addr_a] <= wdata_a;
      if (wr_b)
         mem[gen_addr[1]] <= port_in[1];
   end

   // registered reads, one cycle behind the address
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         out_a <= '0;
         out_b <= '0;
      end else begin
         out_a <= mem[addr_a];
         out_b <= mem[gen_addr[1]];
      end
   end

   assign done_a = gen_done[0];
   assign done_b = gen_done[1];

   // host must stay off the memory while a run streams through it
   a_no_host_in_run: assert property (@(posedge rst) disable iff (clk)
      !(valid && gen_active != 2'b00));

endmodule

// File: source/alu_unit.sv
// ----------------------------------------------------------------------
// alu_unit
// two-operand ALU, operands picked off the data bus, result
// registered and cleared at the start of every run
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_consts.svh"

module alu_unit import dataeng_pkg::*; (
   input  logic                        rst,
   input  logic                        clk,
   input  logic                        run,
   input  logic [`DATABUS_W-1:0]       data_bus,
   input  logic [`ALU_CONF_BITS-1:0]   config_bits,
   output logic [`DATA_W-1:0]          result
);

   alu_op_t               op;
   logic [`DATA_W-1:0]    op_a;
   logic [`DATA_W-1:0]    op_b;
   logic [`DATA_W-1:0]    alu_out;

   assign op   = alu_op_t'(config_bits[`ALU_OP_B +: `ALU_OP_W]);
   assign op_a = bus_pick(data_bus, bus_sel_t'(config_bits[`ALU_SEL_A_B +: `BUS_SEL_W]));
   assign op_b = bus_pick(data_bus, bus_sel_t'(config_bits[`ALU_SEL_B_B +: `BUS_SEL_W]));

   always_comb begin
      case (op)
         alu_add:    alu_out = op_a + op_b;
         alu_sub:    alu_out = op_a - op_b;
         alu_and:    alu_out = op_a & op_b;
         alu_or:     alu_out = op_a | op_b;
         alu_xor:    alu_out = op_a ^ op_b;
         alu_pass_a: alu_out = op_a;
         // spare opcodes give zero
         default:    alu_out = '0;
      endcase
   end

   // one cycle from operands to result
   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         result <= '0;
      else if (run)
         result <= '0;
      else
         result <= alu_out;
   end

endmodule

// File: source/mul_unit.sv
// ----------------------------------------------------------------------
// mul_unit
// multiplier on two data bus words, keeps the low product word
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_consts.svh"

module mul_unit import dataeng_pkg::*; (
   input  logic                        rst,
   input  logic                        clk,
   input  logic                        run,
   input  logic [`DATABUS_W-1:0]       data_bus,
   input  logic [`MUL_CONF_BITS-1:0]   config_bits,
   output logic [`DATA_W-1:0]          result
);

   logic [`DATA_W-1:0]    op_a;
   logic [`DATA_W-1:0]    op_b;
   logic [`DATA_W-1:0]    product;

   assign op_a = bus_pick(data_bus, bus_sel_t'(config_bits[`MUL_SEL_A_B +: `BUS_SEL_W]));
   assign op_b = bus_pick(data_bus, bus_sel_t'(config_bits[`MUL_SEL_B_B +: `BUS_SEL_W]));

   // word-wide product is the low half of the full one
   assign product = op_a * op_b;

   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         result <= '0;
      else if (run)
         result <= '0;
      else
         result <= product;
   end

endmodule

// File: source/data_eng.sv
// ----------------------------------------------------------------------
// data_eng
// reconfigurable data engine top, host decoder and read mux, run
// pulse, configuration shadow and the units on the shared data bus
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_consts.svh"

module data_eng (
   input  logic                      rst,
   input  logic                      clk,
   // host port
   input  logic                      valid,
   input  logic                      we,
   input  logic [`HOST_ADDR_W-1:0]   addr,
   input  logic [`DATA_W-1:0]        wr_data,
   output logic [`DATA_W-1:0]        rd_data,
   // configuration word, sampled on run
   input  logic [`CONF_BITS-1:0]     config_bus
);

   wire  [`DATABUS_W-1:0]    data_bus;
   wire  [2*`N_MEM-1:0]      mem_done;

   logic                     ctrl_valid;
   logic [`N_MEM-1:0]        mem_valid;
   logic [`N_MEM_W-1:0]      mem_idx;
   logic [`DATA_W-1:0]       mem_word;
   logic                     run;
   logic                     run_reg;
   logic [`CONF_BITS-1:0]    config_shadow;

   // top bit picks the control word, else memory index and word
   always_comb begin
      ctrl_valid = 1'b0;
      mem_valid  = '0;
      if (addr[`HOST_ADDR_W-1]) begin
         ctrl_valid = valid;
      end else begin
         for (int m = 0; m < `N_MEM; m++) begin
            if (addr[`N_MEM_W+`MEM_ADDR_W-1 -: `N_MEM_W] == `N_MEM_W'(m))
               mem_valid[m] = valid;
         end
      end
   end

   // memory index of the last host memory access
   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         mem_idx <= '0;
      else if (valid && !addr[`HOST_ADDR_W-1])
         mem_idx <= addr[`N_MEM_W+`MEM_ADDR_W-1 -: `N_MEM_W];
   end

   // port A word of the addressed memory
   always_comb begin
      mem_word = '0;
      for (int m = 0; m < `N_MEM; m++) begin
         if (mem_idx == `N_MEM_W'(m))
            mem_word = data_bus[(`SRC_MEM0A + 2*m)*`DATA_W +: `DATA_W];
      end
   end

   // control read gives the all-done status bit
   always_comb begin
      if (ctrl_valid)
         rd_data = {{(`DATA_W-1){1'b0}}, &mem_done};
      else
         rd_data = mem_word;
   end

   // run pulse, units start one cycle later
   assign run = ctrl_valid && we && wr_data[0];

   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         run_reg <= 1'b0;
      else
         run_reg <= run;
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         config_shadow <= '0;
      else if (run)
         config_shadow <= config_bus;
   end

   // memories, ports A and B on adjacent bus slots
   for (genvar m = 0; m < `N_MEM; m++) begin : g_mem
      mem_unit i_mem_unit (
         .rst         (rst),
         .clk         (clk),
         .run         (run_reg),
         .valid       (mem_valid[m]),
         .we          (we),
         .addr        (addr[`MEM_ADDR_W-1:0]),
         .wr_data     (wr_data),
         .data_bus    (data_bus),
         .config_bits (config_shadow[`CONF_MEM0_B + m*`MEM_CONF_BITS +: `MEM_CONF_BITS]),
         .out_a       (data_bus[(`SRC_MEM0A + 2*m)*`DATA_W +: `DATA_W]),
         .out_b       (data_bus[(`SRC_MEM0B + 2*m)*`DATA_W +: `DATA_W]),
         .done_a      (mem_done[2*m]),
         .done_b      (mem_done[2*m+1])
      );
   end

   alu_unit i_alu_unit (
      .rst         (rst),
      .clk         (clk),
      .run         (run_reg),
      .data_bus    (data_bus),
      .config_bits (config_shadow[`CONF_ALU0_B +: `ALU_CONF_BITS]),
      .result      (data_bus[`SRC_ALU0*`DATA_W +: `DATA_W])
   );

   mul_unit i_mul_unit (
      .rst         (rst),
      .clk         (clk),
      .run         (run_reg),
      .data_bus    (data_bus),
      .config_bits (config_shadow[`CONF_MUL0_B +: `MUL_CONF_BITS]),
      .result      (data_bus[`SRC_MUL0*`DATA_W +: `DATA_W])
   );

   // no host memory access from run start until every port is done
   a_no_host_mem_in_run: assert property (@(posedge rst) disable iff (clk)
      !(|mem_valid && (run_reg || !(&mem_done))));

endmodule

// File: testbench/tb_data_eng.sv
// ----------------------------------------------------------------------
// tb_data_eng
// testbench for the data engine, loads and checks both memories and
// runs ALU, multiply and stride chains against a reference model
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dataeng_consts.svh"

module tb_data_eng import dataeng_pkg::*; ();

   localparam int N_TESTS    = 11;
   localparam int TEST_NS    = 2000;
   localparam int CLK_NS     = 20;
   localparam int RST_CYCLES = 16;
   localparam int POLL_MAX   = 64;

   // clock is rst, reset is clk
   logic                     rst;
   logic                     clk;
   logic                     valid;
   logic                     we;
   logic [`HOST_ADDR_W-1:0]  addr;
   logic [`DATA_W-1:0]       wr_data;
   logic [`DATA_W-1:0]       rd_data;
   logic [`CONF_BITS-1:0]    config_bus;

   integer                   seed;
   int                       error_count;
   logic [`DATA_W-1:0]       model_mem [`N_MEM][`MEM_DEPTH];
   logic [`DATA_W-1:0]       word;

   data_eng i_data_eng (
      .rst        (rst),
      .clk        (clk),
      .valid      (valid),
      .we         (we),
      .addr       (addr),
      .wr_data    (wr_data),
      .rd_data    (rd_data),
      .config_bus (config_bus)
   );

   initial begin
      rst = 1'b0;
      forever #(CLK_NS/2) rst = ~rst;
   end

   task automatic stop_on_error(input string why);
      error_count++;
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] exp);
      if (got !== exp)
         stop_on_error($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                 $time, name, got, exp));
   endtask

   task automatic check_done(input logic got, input logic exp);
      if (got !== exp)
         stop_on_error($sformatf("Mismatch at %0t: all done is %b, expected %b",
                                 $time, got, exp));
   endtask

   // inputs change 2 ns after the rising edge
   task automatic next_cycle();
      @(posedge rst);
      #2;
   endtask

   task automatic host_write(input int m, input int w, input logic [`DATA_W-1:0] data);
      next_cycle();
      valid   = 1'b1;
      we      = 1'b1;
      addr    = {1'b0, `N_MEM_W'(m), `MEM_ADDR_W'(w)};
      wr_data = data;
      next_cycle();
      valid   = 1'b0;
      we      = 1'b0;
   endtask

   // word arrives the cycle after the strobe
   task automatic host_read(input int m, input int w, output logic [`DATA_W-1:0] data);
      next_cycle();
      valid = 1'b1;
      we    = 1'b0;
      addr  = {1'b0, `N_MEM_W'(m), `MEM_ADDR_W'(w)};
      next_cycle();
      valid = 1'b0;
      #8;
      data  = rd_data;
   endtask

   // status is combinational, sampled mid cycle
   task automatic ctrl_read(output logic [`DATA_W-1:0] data);
      next_cycle();
      valid = 1'b1;
      we    = 1'b0;
      addr  = {1'b1, {(`HOST_ADDR_W-1){1'b0}}};
      #8;
      data  = rd_data;
      next_cycle();
      valid = 1'b0;
   endtask

   task automatic start_run(input logic [`CONF_BITS-1:0] cfg);
      next_cycle();
      config_bus = cfg;
      valid      = 1'b1;
      we         = 1'b1;
      addr       = {1'b1, {(`HOST_ADDR_W-1){1'b0}}};
      wr_data    = `DATA_W'(1);
      next_cycle();
      valid      = 1'b0;
      we         = 1'b0;
      wr_data    = '0;
   endtask

   // done must drop soon after the run starts
   task automatic expect_busy();
      logic [`DATA_W-1:0] status;
      bit                 seen;
      seen = 1'b0;
      for (int n = 0; n < 4 && !seen; n++) begin
         ctrl_read(status);
         if (status[0] == 1'b0)
            seen = 1'b1;
      end
      check_done(status[0], 1'b0);
   endtask

   task automatic wait_done();
      logic [`DATA_W-1:0] status;
      status = '0;
      for (int n = 0; n < POLL_MAX && !status[0]; n++)
         ctrl_read(status);
      if (!status[0])
         stop_on_error($sformatf("Run did not finish, done still low at %0t", $time));
   endtask

   task automatic check_memory(input int m);
      logic [`DATA_W-1:0] data;
      for (int w = 0; w < `MEM_DEPTH; w++) begin
         host_read(m, w, data);
         check_word($sformatf("mem%0d[%0d]", m, w), data, model_mem[m][w]);
      end
   endtask

   function automatic logic [`CONF_BITS-1:0] set_port(
      input logic [`CONF_BITS-1:0]    cfg,
      input int                       m,
      input int                       p,
      input mem_mode_t                mode,
      input bus_sel_t                 in_sel,
      input logic [`MEM_ADDR_W-1:0]   start,
      input logic [`MEM_ADDR_W-1:0]   incr,
      input logic [`MEMP_ITER_W-1:0]  iter,
      input logic [`MEMP_DELAY_W-1:0] delay
   );
      logic [`CONF_BITS-1:0] c;
      int                    base;
      c    = cfg;
      base = `CONF_MEM0_B + m*`MEM_CONF_BITS + p*`MEMP_CONF_BITS;
      c[base + `MEMP_MODE_B +: `MEMP_MODE_W]   = mode;
      c[base + `MEMP_IN_SEL_B +: `BUS_SEL_W]   = in_sel;
      c[base + `MEMP_START_B +: `MEM_ADDR_W]   = start;
      c[base + `MEMP_INCR_B +: `MEM_ADDR_W]    = incr;
      c[base + `MEMP_ITER_B +: `MEMP_ITER_W]   = iter;
      c[base + `MEMP_DELAY_B +: `MEMP_DELAY_W] = delay;
      return c;
   endfunction

   function automatic logic [`CONF_BITS-1:0] set_alu(input logic [`CONF_BITS-1:0] cfg,
      input alu_op_t op, input bus_sel_t sel_a, input bus_sel_t sel_b);
      logic [`CONF_BITS-1:0] c;
      c = cfg;
      c[`CONF_ALU0_B + `ALU_OP_B +: `ALU_OP_W]     = op;
      c[`CONF_ALU0_B + `ALU_SEL_A_B +: `BUS_SEL_W] = sel_a;
      c[`CONF_ALU0_B + `ALU_SEL_B_B +: `BUS_SEL_W] = sel_b;
      return c;
   endfunction

   function automatic logic [`CONF_BITS-1:0] set_mul(input logic [`CONF_BITS-1:0] cfg,
      input bus_sel_t sel_a, input bus_sel_t sel_b);
      logic [`CONF_BITS-1:0] c;
      c = cfg;
      c[`CONF_MUL0_B + `MUL_SEL_A_B +: `BUS_SEL_W] = sel_a;
      c[`CONF_MUL0_B + `MUL_SEL_B_B +: `BUS_SEL_W] = sel_b;
      return c;
   endfunction

   // expected image after one chain: two unit-stride source streams,
   // one operation, strided destination where later writes win
   function automatic void predict_run(input int a_mem, input int a_start,
      input int b_mem, input int b_start, input int d_mem, input int d_start,
      input int d_incr, input int iter, input bit use_mul, input alu_op_t op);
      logic [`DATA_W-1:0] snap [`N_MEM][`MEM_DEPTH];
      logic [`DATA_W-1:0] a;
      logic [`DATA_W-1:0] b;
      logic [`DATA_W-1:0] r;
      snap = model_mem;
      for (int k = 0; k < iter; k++) begin
         a = snap[a_mem][(a_start + k) % `MEM_DEPTH];
         b = snap[b_mem][(b_start + k) % `MEM_DEPTH];
         if (use_mul)
            r = a * b;
         else
            case (op)
               alu_add:    r = a + b;
               alu_sub:    r = a - b;
               alu_and:    r = a & b;
               alu_or:     r = a | b;
               alu_xor:    r = a ^ b;
               alu_pass_a: r = a;
               default:    r = '0;
            endcase
         model_mem[d_mem][(d_start + k*d_incr) % `MEM_DEPTH] = r;
      end
   endfunction

   task automatic run_config(input logic [`CONF_BITS-1:0] cfg);
      start_run(cfg);
      expect_busy();
      wait_done();
   endtask

   // mem0 words 0..7 op words 8..15 into mem1 words 0..7
   task automatic run_alu_chain(input alu_op_t op);
      logic [`CONF_BITS-1:0] cfg;
      cfg = '0;
      cfg = set_port(cfg, 0, 0, mem_read, bus_sel_t'(0), 4'd0, 4'd1, 5'd8, 2'd0);
      cfg = set_port(cfg, 0, 1, mem_read, bus_sel_t'(0), 4'd8, 4'd1, 5'd8, 2'd0);
      cfg = set_alu(cfg, op, bus_sel_t'(`SRC_MEM0A), bus_sel_t'(`SRC_MEM0B));
      cfg = set_port(cfg, 1, 0, mem_write, bus_sel_t'(`SRC_ALU0), 4'd0, 4'd1, 5'd8, 2'd2);
      run_config(cfg);
      predict_run(0, 0, 0, 8, 1, 0, 1, 8, 1'b0, op);
      check_memory(1);
   endtask

   // a stream from mem0 port A through pass_a into a strided mem1 write
   task automatic run_stride(input logic [`MEM_ADDR_W-1:0] start,
                             input logic [`MEM_ADDR_W-1:0] incr);
      logic [`CONF_BITS-1:0] cfg;
      cfg = '0;
      cfg = set_port(cfg, 0, 0, mem_read, bus_sel_t'(0), 4'd0, 4'd1, 5'd16, 2'd0);
      cfg = set_alu(cfg, alu_pass_a, bus_sel_t'(`SRC_MEM0A), bus_sel_t'(7));
      cfg = set_port(cfg, 1, 0, mem_write, bus_sel_t'(`SRC_ALU0), start, incr, 5'd16, 2'd2);
      run_config(cfg);
      predict_run(0, 0, 0, 0, 1, int'(start), int'(incr), 16, 1'b0, alu_pass_a);
      check_memory(1);
   endtask

   initial begin
      logic [`CONF_BITS-1:0] cfg;
      seed        = 32'h7e00_fb02;
      error_count = 0;
      valid       = 1'b0;
      we          = 1'b0;
      addr        = '0;
      wr_data     = '0;
      config_bus  = '0;
      clk         = 1'b1;
      repeat (RST_CYCLES) @(posedge rst);
      #2;
      clk = 1'b0;

      // idle engine reports done, memories hold random words
      ctrl_read(word);
      check_word("rd_data", word, `DATA_W'(1));
      for (int m = 0; m < `N_MEM; m++)
         for (int w = 0; w < `MEM_DEPTH; w++) begin
            model_mem[m][w] = $random(seed);
            host_write(m, w, model_mem[m][w]);
         end
      check_memory(0);
      check_memory(1);

      run_alu_chain(alu_add);
      for (int i = 0; i <= int'(alu_pass_a); i++)
         run_alu_chain(alu_op_t'(i));

      // mem0A times mem1B into mem0 words 8..15 through port B
      cfg = '0;
      cfg = set_port(cfg, 0, 0, mem_read, bus_sel_t'(0), 4'd0, 4'd1, 5'd8, 2'd0);
      cfg = set_port(cfg, 1, 1, mem_read, bus_sel_t'(0), 4'd8, 4'd1, 5'd8, 2'd0);
      cfg = set_mul(cfg, bus_sel_t'(`SRC_MEM0A), bus_sel_t'(`SRC_MEM1B));
      cfg = set_port(cfg, 0, 1, mem_write, bus_sel_t'(`SRC_MUL0), 4'd8, 4'd1, 5'd8, 2'd2);
      run_config(cfg);
      predict_run(0, 0, 1, 8, 0, 8, 1, 8, 1'b1, alu_add);
      check_memory(0);

      // stride 3 wraps, stride 4 rewrites every fourth word
      run_stride(4'd5, 4'd3);
      run_stride(4'd0, 4'd4);

      if (error_count == 0) begin
         $display("** PASS **");
         $finish;
      end else begin
         stop_on_error("Errors were counted during the run");
      end
   end

   // run time bound from the number of tests plus reset
   initial begin
      #(N_TESTS * TEST_NS + RST_CYCLES * CLK_NS);
      stop_on_error($sformatf("Watchdog expired at %0t, tests did not complete", $time));
   end

endmodule

// File: data_eng.f
+incdir+common
common/dataeng_pkg.sv
mem_unit/addr_gen.sv
mem_unit/mem_unit.sv
source/alu_unit.sv
source/mul_unit.sv
source/data_eng.sv
testbench/tb_data_eng.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the data engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_data_eng -f data_eng.f -o tb_data_eng > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_data_eng > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "simulation passed" && exit 0 \
   || { echo "simulation failed"; exit 1; }
